//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0 -Wno-fatal
TOP       := blk_crypt_tb
FILELIST  := compile.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/blk_crypt_tb.sv
// Testbench for the cipher engine with a memory model, random jobs and a reference cipher model
`timescale 1ns/1ps

module blk_crypt_tb;
  import blk_crypt_pkg::*;

  localparam int MEM_WORDS      = 1024;
  localparam int PAIRS          = 5;
  localparam int JOBS           = 2 * PAIRS + 2;
  localparam int BLK_CYCLES     = 80;
  localparam int TIMEOUT_CYCLES = JOBS * 4 * BLK_CYCLES + 500;

  logic     clk = 1'b0;
  logic     reset_n = 1'b0;
  logic     start = 1'b0;
  job_cfg_t cfg = '0;
  mem_rd_t  mem_rd;
  word_t    rd_data = '0;
  logic     rd_valid = 1'b0;
  mem_wr_t  mem_wr;
  logic     wr_done = 1'b0;
  logic     done;

  integer     seed = 32'h736e;
  int         cycle_cnt = 0;
  word_t      mem [0:MEM_WORDS-1];
  logic [9:0] rd_idx = '0;
  logic [2:0] rd_wait = '0;
  logic [2:0] wr_wait = '0;
  blk_cnt_t   rd_total = '0;
  blk_cnt_t   wr_total = '0;
  blk_cnt_t   done_total = '0;

  blk_crypt_top blk_crypt_top_inst (
    .clk, .reset_n, .start_i(start), .cfg_i(cfg),
    .mem_rd_o(mem_rd), .rd_data_i(rd_data), .rd_valid_i(rd_valid),
    .mem_wr_o(mem_wr), .wr_done_i(wr_done), .done_o(done)
  );

  always #2 clk = ~clk;

  // Memory answers each request after 1 to 4 cycles
  always @(posedge clk) begin
    rd_valid <= 1'b0;
    wr_done  <= 1'b0;
    if (mem_rd.req) begin
      rd_idx   <= mem_rd.addr[11:2];
      rd_wait  <= 3'd1 + 3'($unsigned($random(seed)) % 32'd4);
      rd_total <= rd_total + 16'd1;
    end else if (rd_wait != 3'd0) begin
      rd_wait <= rd_wait - 3'd1;
      if (rd_wait == 3'd1) begin
        rd_valid <= 1'b1;
        rd_data  <= mem[rd_idx];
      end
    end
    if (mem_wr.req) begin
      mem[mem_wr.addr[11:2]] = mem_wr.data;
      wr_wait  <= 3'd1 + 3'($unsigned($random(seed)) % 32'd4);
      wr_total <= wr_total + 16'd1;
    end else if (wr_wait != 3'd0) begin
      wr_wait <= wr_wait - 3'd1;
      if (wr_wait == 3'd1)
        wr_done <= 1'b1;
    end
    if (done)
      done_total <= done_total + 16'd1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1);
    end
  end

  function automatic key_t round_key(input key_t key, input int r);
    key_t rk;
    rk = key;
    for (int i = 0; i < r; i++)
      rk = {rk[95:0], rk[127:96]};
    rk[7:0] = rk[7:0] ^ 8'(r + 1);
    return rk;
  endfunction

  function automatic block_t encrypt_block(input key_t key, input block_t blk);
    block_t x;
    x = blk;
    for (int r = 0; r < ROUNDS; r++) begin
      x = x ^ round_key(key, r);
      x = (x << ROT) | (x >> (128 - ROT));
    end
    return x;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input blk_cnt_t got, input blk_cnt_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic run_job(input addr_t src, input addr_t dst, input len_t len,
                         input key_t key, input logic dec);
    @(posedge clk);
    cfg   <= '{src_addr: src, dst_addr: dst, byte_len: len, key: key, decrypt: dec};
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do
      @(posedge clk);
    while (!done);
    // Leave room for a stray second done pulse
    repeat (4) @(posedge clk);
  endtask

  // Guard word past the last block, access counts and a single done pulse
  task automatic check_tail(input addr_t dst, input int nblk, input word_t guard,
                            input blk_cnt_t rd0, input blk_cnt_t wr0,
                            input blk_cnt_t dn0);
    check_word("word past last block", mem[(dst >> 2) + 4 * nblk], guard);
    check_count("read count", rd_total - rd0, blk_cnt_t'(4 * nblk));
    check_count("write count", wr_total - wr0, blk_cnt_t'(4 * nblk));
    check_count("done count", done_total - dn0, 16'd1);
  endtask

  task automatic empty_job(input addr_t src, input addr_t dst);
    blk_cnt_t rd0;
    blk_cnt_t wr0;
    blk_cnt_t dn0;
    rd0 = rd_total;
    wr0 = wr_total;
    dn0 = done_total;
    run_job(src, dst, '0, '0, 1'b0);
    check_count("read count", rd_total - rd0, '0);
    check_count("write count", wr_total - wr0, '0);
    check_count("done count", done_total - dn0, 16'd1);
  endtask

  initial begin
    key_t     key;
    addr_t    src;
    addr_t    dst;
    addr_t    back;
    len_t     len;
    int       nblk;
    int       trim;
    word_t    plain [0:15];
    word_t    guard;
    blk_cnt_t rd0;
    blk_cnt_t wr0;
    blk_cnt_t dn0;
    block_t   exp;

    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;

    empty_job(32'h100, 32'h900);
    for (int i = 0; i < PAIRS; i++) begin
      key  = {$random(seed), $random(seed), $random(seed), $random(seed)};
      nblk = 1 + int'($unsigned($random(seed)) % 4);
      trim = int'($unsigned($random(seed)) % 16);
      // At least one job with a partial tail block
      if (i == 0 && trim == 0)
        trim = 7;
      len  = len_t'(16 * nblk - trim);
      src  = addr_t'(4 * ($unsigned($random(seed)) % 448));
      dst  = addr_t'(2048 + 4 * ($unsigned($random(seed)) % 448));
      back = addr_t'(4 * ($unsigned($random(seed)) % 448));
      for (int w = 0; w < 4 * nblk; w++) begin
        plain[w] = $random(seed);
        mem[(src >> 2) + w] = plain[w];
      end

      guard = mem[(dst >> 2) + 4 * nblk];
      rd0   = rd_total;
      wr0   = wr_total;
      dn0   = done_total;
      run_job(src, dst, len, key, 1'b0);
      for (int b = 0; b < nblk; b++) begin
        exp = encrypt_block(key, {plain[4*b+3], plain[4*b+2], plain[4*b+1], plain[4*b]});
        for (int w = 0; w < 4; w++)
          check_word("ciphertext word", mem[(dst >> 2) + 4 * b + w], exp[32*w +: 32]);
      end
      check_tail(dst, nblk, guard, rd0, wr0, dn0);

      guard = mem[(back >> 2) + 4 * nblk];
      rd0   = rd_total;
      wr0   = wr_total;
      dn0   = done_total;
      run_job(dst, back, len, key, 1'b1);
      for (int w = 0; w < 4 * nblk; w++)
        check_word("decrypted word", mem[(back >> 2) + w], plain[w]);
      check_tail(back, nblk, guard, rd0, wr0, dn0);
    end
    empty_job(32'h200, 32'hA00);

    $display("test passed");
    $finish;
  end

endmodule

//--- compile.f
src/blk_crypt_pkg.sv
src/key_schedule.sv
src/word_fetch.sv
src/round_engine.sv
src/word_store.sv
src/crypt_ctrl.sv
src/blk_crypt_top.sv
bench/blk_crypt_tb.sv

//--- src/blk_crypt_pkg.sv
// Shared widths, job and memory structs and controller states for the block cipher engine
package blk_crypt_pkg;

  // Cipher shape
  localparam int ROUNDS        = 4;
  localparam int ROT           = 13;
  localparam int WORDS_PER_BLK = 4;
  localparam int BLK_BYTES     = 16;

  typedef logic [31:0]  word_t;
  typedef logic [31:0]  addr_t;
  typedef logic [127:0] block_t;
  typedef logic [127:0] key_t;
  typedef logic [31:0]  len_t;
  typedef logic [1:0]   word_idx_t;
  typedef logic [15:0]  blk_cnt_t;

  // Round counter in key schedule and core
  typedef logic [$clog2(ROUNDS)-1:0] round_idx_t;

  typedef key_t [ROUNDS-1:0] round_keys_t;

  typedef struct packed {
    addr_t src_addr;
    addr_t dst_addr;
    len_t  byte_len;
    key_t  key;
    logic  decrypt;
  } job_cfg_t;

  typedef struct packed {
    logic  req;
    addr_t addr;
  } mem_rd_t;

  typedef struct packed {
    logic  req;
    addr_t addr;
    word_t data;
  } mem_wr_t;

  typedef enum logic [3:0] {
    CTRL_IDLE,
    CTRL_INIT_KEY,
    CTRL_WAIT_KEY,
    CTRL_FETCH,
    CTRL_FETCH_WAIT,
    CTRL_START_CORE,
    CTRL_WAIT_CORE,
    CTRL_STORE,
    CTRL_STORE_WAIT,
    CTRL_BLOCK_DONE,
    CTRL_FINISHED
  } ctrl_state_t;

endpackage

//--- src/blk_crypt_top.sv
// Top level of the memory to memory cipher engine, wiring controller and datapath stages
`timescale 1ns/1ps

module blk_crypt_top (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    start_i,
  input  blk_crypt_pkg::job_cfg_t cfg_i,
  output blk_crypt_pkg::mem_rd_t  mem_rd_o,
  input  blk_crypt_pkg::word_t    rd_data_i,
  input  logic                    rd_valid_i,
  output blk_crypt_pkg::mem_wr_t  mem_wr_o,
  input  logic                    wr_done_i,
  output logic                    done_o
);
  import blk_crypt_pkg::*;

  logic        key_init;
  logic        key_ready;
  logic        fetch_req;
  logic        fetch_clear;
  logic        fetch_done;
  logic        core_start;
  logic        core_ready;
  logic        store_req;
  logic        store_done;
  word_idx_t   word_idx;
  addr_t       rd_addr;
  addr_t       wr_addr;
  round_keys_t round_keys;
  block_t      in_blk;
  block_t      out_blk;

  crypt_ctrl ctrl_inst (
    .clk, .reset_n, .start_i, .cfg_i,
    .key_init_o(key_init), .key_ready_i(key_ready),
    .fetch_req_o(fetch_req), .fetch_clear_o(fetch_clear), .fetch_done_i(fetch_done),
    .core_start_o(core_start), .core_ready_i(core_ready),
    .store_req_o(store_req), .store_done_i(store_done),
    .word_idx_o(word_idx), .rd_addr_o(rd_addr), .wr_addr_o(wr_addr), .done_o
  );

  key_schedule key_schedule_inst (
    .clk, .reset_n, .key_init_i(key_init), .key_i(cfg_i.key),
    .round_keys_o(round_keys), .key_ready_o(key_ready)
  );

  word_fetch word_fetch_inst (
    .clk, .reset_n, .clear_i(fetch_clear), .fetch_req_i(fetch_req),
    .addr_i(rd_addr), .word_idx_i(word_idx), .mem_rd_o, .rd_data_i, .rd_valid_i,
    .block_o(in_blk), .fetch_done_o(fetch_done)
  );

  round_engine round_engine_inst (
    .clk, .reset_n, .core_start_i(core_start), .decrypt_i(cfg_i.decrypt),
    .block_i(in_blk), .round_keys_i(round_keys), .block_o(out_blk),
    .core_ready_o(core_ready)
  );

  word_store word_store_inst (
    .clk, .reset_n, .store_req_i(store_req), .addr_i(wr_addr), .word_idx_i(word_idx),
    .block_i(out_blk), .mem_wr_o, .wr_done_i, .store_done_o(store_done)
  );

endmodule

//--- src/crypt_ctrl.sv
// Job sequencer: key setup, word fetch loop, core pass, word store loop and block counting
`timescale 1ns/1ps

module crypt_ctrl (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     start_i,
  input  blk_crypt_pkg::job_cfg_t  cfg_i,
  output logic                     key_init_o,
  input  logic                     key_ready_i,
  output logic                     fetch_req_o,
  output logic                     fetch_clear_o,
  input  logic                     fetch_done_i,
  output logic                     core_start_o,
  input  logic                     core_ready_i,
  output logic                     store_req_o,
  input  logic                     store_done_i,
  output blk_crypt_pkg::word_idx_t word_idx_o,
  output blk_crypt_pkg::addr_t     rd_addr_o,
  output blk_crypt_pkg::addr_t     wr_addr_o,
  output logic                     done_o
);
  import blk_crypt_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  word_idx_t   word_q;
  blk_cnt_t    blk_idx_q;
  blk_cnt_t    blk_left_q;
  blk_cnt_t    blk_total;
  len_t        len_up;
  addr_t       blk_offs;
  logic        last_word;
  logic        last_blk;

  // Length rounded up to whole blocks
  assign len_up    = cfg_i.byte_len + len_t'(BLK_BYTES - 1);
  assign blk_total = blk_cnt_t'(len_up / BLK_BYTES);

  assign last_word = (word_q == word_idx_t'(WORDS_PER_BLK - 1));
  assign last_blk  = (blk_left_q == blk_cnt_t'(1));

  assign blk_offs  = addr_t'(blk_idx_q) * addr_t'(BLK_BYTES) + (addr_t'(word_q) << 2);
  assign rd_addr_o = cfg_i.src_addr + blk_offs;
  assign wr_addr_o = cfg_i.dst_addr + blk_offs;
  assign word_idx_o = word_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      state_q <= CTRL_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      word_q     <= '0;
      blk_idx_q  <= '0;
      blk_left_q <= '0;
    end else begin
      case (state_q)
        CTRL_INIT_KEY: begin
          word_q     <= '0;
          blk_idx_q  <= '0;
          blk_left_q <= blk_total;
        end
        CTRL_FETCH_WAIT: begin
          if (fetch_done_i)
            word_q <= word_q + 1'b1;
        end
        CTRL_STORE_WAIT: begin
          if (store_done_i)
            word_q <= word_q + 1'b1;
        end
        CTRL_BLOCK_DONE: begin
          blk_idx_q  <= blk_idx_q + 1'b1;
          blk_left_q <= blk_left_q - 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (start_i)
          state_d = CTRL_INIT_KEY;
      end
      CTRL_INIT_KEY: begin
        // Nothing to do for an empty job
        state_d = (blk_total == '0) ? CTRL_FINISHED : CTRL_WAIT_KEY;
      end
      CTRL_WAIT_KEY: begin
        if (key_ready_i)
          state_d = CTRL_FETCH;
      end
      CTRL_FETCH:      state_d = CTRL_FETCH_WAIT;
      CTRL_FETCH_WAIT: begin
        if (fetch_done_i)
          state_d = last_word ? CTRL_START_CORE : CTRL_FETCH;
      end
      CTRL_START_CORE: state_d = CTRL_WAIT_CORE;
      CTRL_WAIT_CORE: begin
        if (core_ready_i)
          state_d = CTRL_STORE;
      end
      CTRL_STORE:      state_d = CTRL_STORE_WAIT;
      CTRL_STORE_WAIT: begin
        if (store_done_i)
          state_d = last_word ? CTRL_BLOCK_DONE : CTRL_STORE;
      end
      CTRL_BLOCK_DONE: state_d = last_blk ? CTRL_FINISHED : CTRL_FETCH;
      CTRL_FINISHED:   state_d = CTRL_IDLE;
      default:         state_d = CTRL_IDLE;
    endcase
  end

  assign key_init_o    = (state_q == CTRL_INIT_KEY) && (blk_total != '0);
  assign fetch_req_o   = (state_q == CTRL_FETCH);
  assign fetch_clear_o = (state_q == CTRL_INIT_KEY) || (state_q == CTRL_BLOCK_DONE);
  assign core_start_o  = (state_q == CTRL_START_CORE);
  assign store_req_o   = (state_q == CTRL_STORE);
  assign done_o        = (state_q == CTRL_FINISHED);

endmodule

//--- src/key_schedule.sv
// Round key generator, one key per cycle after key init, keys held for the whole job
`timescale 1ns/1ps

module key_schedule (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       key_init_i,
  input  blk_crypt_pkg::key_t        key_i,
  output blk_crypt_pkg::round_keys_t round_keys_o,
  output logic                       key_ready_o
);
  import blk_crypt_pkg::*;

  logic        busy_q;
  round_idx_t  rnd_q;
  key_t        rot_key_q;
  round_keys_t keys_q;
  logic [7:0]  rcon;

  // Round constant goes into the low byte
  assign rcon = 8'(rnd_q) + 8'd1;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      rnd_q  <= '0;
    end else if (key_init_i) begin
      busy_q <= 1'b1;
      rnd_q  <= '0;
    end else if (busy_q) begin
      rnd_q <= rnd_q + 1'b1;
      if (rnd_q == round_idx_t'(ROUNDS - 1))
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (key_init_i) begin
      rot_key_q <= key_i;
    end else if (busy_q) begin
      keys_q[rnd_q] <= rot_key_q ^ key_t'(rcon);
      // Next key is rotated one more word
      rot_key_q     <= {rot_key_q[95:0], rot_key_q[127:96]};
    end
  end

  assign round_keys_o = keys_q;
  assign key_ready_o  = ~busy_q;

endmodule

//--- src/round_engine.sv
// Iterated toy cipher core, one round per cycle, encrypt or decrypt
`timescale 1ns/1ps

module round_engine (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       core_start_i,
  input  logic                       decrypt_i,
  input  blk_crypt_pkg::block_t      block_i,
  input  blk_crypt_pkg::round_keys_t round_keys_i,
  output blk_crypt_pkg::block_t      block_o,
  output logic                       core_ready_o
);
  import blk_crypt_pkg::*;

  logic       busy_q;
  round_idx_t rnd_q;
  round_idx_t key_sel;
  block_t     state_q;
  block_t     mixed;
  block_t     next_state;

  // Decrypt walks the keys backwards
  assign key_sel = decrypt_i ? round_idx_t'(ROUNDS - 1) - rnd_q : rnd_q;

  always_comb begin
    if (decrypt_i) begin
      mixed      = {state_q[ROT-1:0], state_q[127:ROT]};
      next_state = mixed ^ round_keys_i[key_sel];
    end else begin
      mixed      = state_q ^ round_keys_i[key_sel];
      next_state = {mixed[127-ROT:0], mixed[127:128-ROT]};
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      rnd_q  <= '0;
    end else if (core_start_i) begin
      busy_q <= 1'b1;
      rnd_q  <= '0;
    end else if (busy_q) begin
      rnd_q <= rnd_q + 1'b1;
      if (rnd_q == round_idx_t'(ROUNDS - 1))
        busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (core_start_i)
      state_q <= block_i;
    else if (busy_q)
      state_q <= next_state;
  end

  assign block_o      = state_q;
  assign core_ready_o = ~busy_q;

endmodule

//--- src/word_fetch.sv
// Read side: one memory word per request, assembled into the input block register
`timescale 1ns/1ps

module word_fetch (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     clear_i,
  input  logic                     fetch_req_i,
  input  blk_crypt_pkg::addr_t     addr_i,
  input  blk_crypt_pkg::word_idx_t word_idx_i,
  output blk_crypt_pkg::mem_rd_t   mem_rd_o,
  input  blk_crypt_pkg::word_t     rd_data_i,
  input  logic                     rd_valid_i,
  output blk_crypt_pkg::block_t    block_o,
  output logic                     fetch_done_o
);
  import blk_crypt_pkg::*;

  logic      rd_req_q;
  addr_t     rd_addr_q;
  logic      pend_q;
  word_idx_t idx_q;
  block_t    blk_q;
  logic      done_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_req_q <= 1'b0;
      pend_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      rd_req_q <= fetch_req_i;
      done_q   <= rd_valid_i & pend_q;
      if (fetch_req_i)
        pend_q <= 1'b1;
      else if (rd_valid_i)
        pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_req_i) begin
      rd_addr_q <= addr_i;
      idx_q     <= word_idx_i;
    end
  end

  // Returned word lands in its lane
  always_ff @(posedge clk) begin
    if (clear_i)
      blk_q <= '0;
    else if (rd_valid_i && pend_q)
      blk_q[$bits(word_t)*idx_q +: $bits(word_t)] <= rd_data_i;
  end

  assign mem_rd_o.req  = rd_req_q;
  assign mem_rd_o.addr = rd_addr_q;
  assign block_o       = blk_q;
  assign fetch_done_o  = done_q;

endmodule

//--- src/word_store.sv
// Write side: one lane of the result block to memory per request
`timescale 1ns/1ps

module word_store (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     store_req_i,
  input  blk_crypt_pkg::addr_t     addr_i,
  input  blk_crypt_pkg::word_idx_t word_idx_i,
  input  blk_crypt_pkg::block_t    block_i,
  output blk_crypt_pkg::mem_wr_t   mem_wr_o,
  input  logic                     wr_done_i,
  output logic                     store_done_o
);
  import blk_crypt_pkg::*;

  logic  wr_req_q;
  addr_t wr_addr_q;
  word_t wr_data_q;
  logic  pend_q;
  logic  done_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_req_q <= 1'b0;
      pend_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      wr_req_q <= store_req_i;
      done_q   <= wr_done_i & pend_q;
      if (store_req_i)
        pend_q <= 1'b1;
      else if (wr_done_i)
        pend_q <= 1'b0;
    end
  end

  // Lane select at request time
  always_ff @(posedge clk) begin
    if (store_req_i) begin
      wr_addr_q <= addr_i;
      wr_data_q <= block_i[$bits(word_t)*word_idx_i +: $bits(word_t)];
    end
  end

  assign mem_wr_o.req  = wr_req_q;
  assign mem_wr_o.addr = wr_addr_q;
  assign mem_wr_o.data = wr_data_q;
  assign store_done_o  = done_q;

endmodule
